// ==== heapGeometryPkg.sv ====
// --------------------------------------------------------------------------
// Geometry of the array heap
// Widths and counts shared by every stage and by the testbench
// --------------------------------------------------------------------------
`default_nettype none

package heapGeometryPkg;

  localparam int arrayBits   = 2;                     // Array number width
  localparam int arrayCount  = 1 << arrayBits;        // Arrays in the heap
  localparam int indexBits   = 2;                     // Element index width
  localparam int arrayLength = 1 << indexBits;        // Elements per array
  localparam int sizeBits    = indexBits + 1;         // Holds 0 to arrayLength
  localparam int dataBits    = 12;                    // Element width

endpackage

`default_nettype wire

// ==== heapOpPkg.sv ====
// --------------------------------------------------------------------------
// Operation codes, error codes and the result word
// The result word is read as element data or as a handle with a size
// --------------------------------------------------------------------------
`default_nettype none

package heapOpPkg;

  // Bits above the handle and size fields of the result word
  localparam int padBits = heapGeometryPkg::dataBits - heapGeometryPkg::arrayBits
                           - heapGeometryPkg::sizeBits;

  typedef enum logic [3:0] {
    opClear,                                          // Drop every array
    opAlloc,                                          // New or reused array
    opFree,                                           // Give array back
    opWrite,                                          // Store, grows size
    opRead,                                           // Fetch in bounds
    opSize,                                           // Current size
    opPush,                                           // Append at size
    opPop,                                            // Remove last
    opAdd,                                            // Add, new value out
    opAddAfter,                                       // Add, old value out
    opSubtract,                                       // Sub, new value out
    opSubAfter,                                       // Sub, old value out
    opAnd,
    opOr,
    opXor
  } heapOpE;

  typedef enum logic [2:0] {
    errNone,
    errNotAllocated,                                  // Never handed out
    errFreed,                                         // Handed out then freed
    errOutOfBounds,                                   // Index past size
    errFull,                                          // Push on full array
    errEmpty,                                         // Pop on empty array
    errOutOfMemory                                    // No array left
  } heapErrE;

  typedef union packed {
    logic [heapGeometryPkg::dataBits-1:0] data;       // Element view
    struct packed {
      logic [padBits-1:0]                   pad;      // Always zero
      logic [heapGeometryPkg::arrayBits-1:0] handle;  // Array number
      logic [heapGeometryPkg::sizeBits-1:0]  size;    // Elements in use
    } handleView;
  } heapResultU;

endpackage

`default_nettype wire

// ==== heapStageIf.sv ====
// --------------------------------------------------------------------------
// One request item travelling between pipeline stages
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

interface heapStageIf;

  logic                                   valid;      // Item present, one cycle
  heapOpPkg::heapOpE                      op;
  logic [heapGeometryPkg::arrayBits-1:0]  array;      // Array or alloc handle
  logic [heapGeometryPkg::indexBits-1:0]  index;      // Client index
  heapOpPkg::heapResultU                  data;       // Operand or result
  heapOpPkg::heapErrE                     error;      // First failure seen
  logic [heapGeometryPkg::indexBits-1:0]  slot;       // Resolved element

  modport source (
    output valid, op, array, index, data, error, slot
  );

  modport sink (
    input valid, op, array, index, data, error, slot
  );

endinterface

`default_nettype wire

// ==== heapRequestPort.sv ====
// --------------------------------------------------------------------------
// Four-phase request port
// Captures a request, launches it down the pipeline, holds the response
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module heapRequestPort (
  input  logic                                  clock,
  input  logic                                  resetN,
  input  logic                                  req,
  input  heapOpPkg::heapOpE                     op,
  input  logic [heapGeometryPkg::arrayBits-1:0] array,
  input  logic [heapGeometryPkg::indexBits-1:0] index,
  input  logic [heapGeometryPkg::dataBits-1:0]  data,
  output logic                                  ack,
  output heapOpPkg::heapResultU                 result,
  output heapOpPkg::heapErrE                    error,
  heapStageIf.source                            toCheck,
  heapStageIf.sink                              fromAccess
);

  logic busy;                                         // Request in flight
  logic acked;                                        // Waiting for req low
  logic issue;                                        // Launch next cycle

  logic idle;
  assign idle = !busy && !acked;
  assign ack  = acked;

  // --------------------------------------------------------------------------
  // Handshake state
  // --------------------------------------------------------------------------
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      busy          <= 1'b0;
      acked         <= 1'b0;
      issue         <= 1'b0;
      toCheck.valid <= 1'b0;
    end else begin
      toCheck.valid <= issue;                         // Single cycle pulse
      issue         <= 1'b0;
      if (idle && req) begin                          // Phase 1 seen
        busy  <= 1'b1;
        issue <= 1'b1;
      end else if (busy && fromAccess.valid) begin    // Response back
        busy  <= 1'b0;
        acked <= 1'b1;
      end else if (acked && !req) begin               // Phase 3 seen
        acked <= 1'b0;
      end
    end
  end

  // Request fields and held response
  always_ff @(posedge clock) begin
    if (idle && req) begin
      toCheck.op    <= op;
      toCheck.array <= array;
      toCheck.index <= index;
      toCheck.slot  <= index;                         // Check stage may override
      toCheck.data  <= data;
      toCheck.error <= heapOpPkg::errNone;
    end
    if (busy && fromAccess.valid) begin
      result <= fromAccess.data;
      error  <= fromAccess.error;
    end
  end

endmodule

`default_nettype wire

// ==== heapCheckStage.sv ====
// --------------------------------------------------------------------------
// Check stage
// Allocation flags, array sizes, free stack and permission checks
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module heapCheckStage (
  input  logic        clock,
  input  logic        resetN,
  heapStageIf.sink    fromPort,
  heapStageIf.source  toAccess
);

  localparam int aBits = heapGeometryPkg::arrayBits;
  localparam int sBits = heapGeometryPkg::sizeBits;
  localparam int aCnt  = heapGeometryPkg::arrayCount;

  logic             allocated [aCnt];                 // Array in use
  logic [sBits-1:0] sizes     [aCnt];                 // Elements in use
  logic [aBits-1:0] freeStack [aCnt];                 // Freed arrays, LIFO
  logic [aBits:0]   freeTop;                          // Entries on free stack
  logic [aBits:0]   freshCount;                       // Arrays ever handed out

  heapOpPkg::heapErrE                   errC;
  logic [heapGeometryPkg::indexBits-1:0] slotC;
  logic [aBits-1:0]                     handleC;      // Alloc pick
  logic [sBits-1:0]                     sizeNow;
  logic [sBits-1:0]                     sizeLess;
  logic                                 fromStack;    // Alloc reuses freed
  logic                                 isArith;

  // --------------------------------------------------------------------------
  // Validation and slot resolution
  // --------------------------------------------------------------------------
  always_comb begin
    sizeNow   = sizes[fromPort.array];
    sizeLess  = sizeNow - 1'b1;
    isArith   = fromPort.op inside {heapOpPkg::opAdd, heapOpPkg::opAddAfter,
                heapOpPkg::opSubtract, heapOpPkg::opSubAfter, heapOpPkg::opAnd,
                heapOpPkg::opOr, heapOpPkg::opXor};
    fromStack = freeTop != '0;
    handleC   = fromStack ? freeStack[freeTop[aBits-1:0] - 1'b1]
                          : freshCount[aBits-1:0];
    errC      = fromPort.error;                       // Keep earlier failure
    slotC     = fromPort.slot;
    if (fromPort.op == heapOpPkg::opPush) slotC = sizeNow[sBits-2:0];
    if (fromPort.op == heapOpPkg::opPop)  slotC = sizeLess[sBits-2:0];

    if (errC == heapOpPkg::errNone) begin
      if (fromPort.op == heapOpPkg::opAlloc) begin
        if (!fromStack && freshCount >= aCnt) errC = heapOpPkg::errOutOfMemory;
      end else if (fromPort.op != heapOpPkg::opClear) begin
        if ({1'b0, fromPort.array} >= freshCount) begin
          errC = heapOpPkg::errNotAllocated;
        end else if (!allocated[fromPort.array]) begin
          errC = heapOpPkg::errFreed;
        end else if ((isArith || fromPort.op == heapOpPkg::opRead)
                     && {1'b0, fromPort.index} >= sizeNow) begin
          errC = heapOpPkg::errOutOfBounds;
        end else if (fromPort.op == heapOpPkg::opPush
                     && sizeNow == heapGeometryPkg::arrayLength) begin
          errC = heapOpPkg::errFull;
        end else if (fromPort.op == heapOpPkg::opPop && sizeNow == '0) begin
          errC = heapOpPkg::errEmpty;
        end
      end
    end
  end

  // --------------------------------------------------------------------------
  // Table updates
  // --------------------------------------------------------------------------
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      toAccess.valid <= 1'b0;
      freeTop        <= '0;
      freshCount     <= '0;
      for (int a = 0; a < aCnt; a++) begin
        allocated[a] <= 1'b0;
        sizes[a]     <= '0;
      end
    end else begin
      toAccess.valid <= fromPort.valid;
      if (fromPort.valid && errC == heapOpPkg::errNone) begin
        case (fromPort.op)
          heapOpPkg::opClear: begin                   // Forget everything
            freeTop    <= '0;
            freshCount <= '0;
            for (int a = 0; a < aCnt; a++) begin
              allocated[a] <= 1'b0;
              sizes[a]     <= '0;
            end
          end
          heapOpPkg::opAlloc: begin
            allocated[handleC] <= 1'b1;
            sizes[handleC]     <= '0;
            if (fromStack) freeTop <= freeTop - 1'b1;
            else           freshCount <= freshCount + 1'b1;
          end
          heapOpPkg::opFree: begin
            allocated[fromPort.array] <= 1'b0;
            freeTop                   <= freeTop + 1'b1;
          end
          heapOpPkg::opWrite: begin                   // Grow to cover index
            if ({1'b0, fromPort.index} >= sizeNow)
              sizes[fromPort.array] <= {1'b0, fromPort.index} + 1'b1;
          end
          heapOpPkg::opPush: sizes[fromPort.array] <= sizeNow + 1'b1;
          heapOpPkg::opPop:  sizes[fromPort.array] <= sizeLess;
          default: ;                                  // Sizes unchanged
        endcase
      end
    end
  end

  // Free stack contents and item payload
  always_ff @(posedge clock) begin
    if (fromPort.valid && errC == heapOpPkg::errNone
        && fromPort.op == heapOpPkg::opFree)
      freeStack[freeTop[aBits-1:0]] <= fromPort.array;
    toAccess.op    <= fromPort.op;
    toAccess.slot  <= slotC;
    toAccess.error <= errC;
    toAccess.array <= (fromPort.op == heapOpPkg::opAlloc) ? handleC : fromPort.array;
    toAccess.data  <= fromPort.data;
    if (fromPort.op == heapOpPkg::opSize) begin       // Size rides in data
      toAccess.data                 <= '0;
      toAccess.data.handleView.size <= sizeNow;
    end
  end

endmodule

`default_nettype wire

// ==== heapAccessStage.sv ====
// --------------------------------------------------------------------------
// Access stage
// Element memory, element arithmetic and the response word
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module heapAccessStage (
  input  logic        clock,
  input  logic        resetN,
  heapStageIf.sink    fromCheck,
  heapStageIf.source  toPort
);

  localparam int dBits = heapGeometryPkg::dataBits;

  logic [dBits-1:0] mem [heapGeometryPkg::arrayCount][heapGeometryPkg::arrayLength];

  logic [dBits-1:0]      oldVal;                      // Element before update
  logic [dBits-1:0]      operand;
  logic [dBits-1:0]      newVal;                      // Element after update
  logic                  store;                       // Write newVal back
  heapOpPkg::heapResultU resultC;

  assign oldVal  = mem[fromCheck.array][fromCheck.slot];
  assign operand = fromCheck.data.data;

  // --------------------------------------------------------------------------
  // Element update and result selection
  // --------------------------------------------------------------------------
  always_comb begin
    newVal       = oldVal;
    store        = 1'b1;
    resultC      = '0;
    resultC.data = oldVal;
    case (fromCheck.op)
      heapOpPkg::opWrite,
      heapOpPkg::opPush:     newVal = operand;
      heapOpPkg::opAdd,
      heapOpPkg::opAddAfter: newVal = oldVal + operand;    // Wraps mod 4096
      heapOpPkg::opSubtract,
      heapOpPkg::opSubAfter: newVal = oldVal - operand;
      heapOpPkg::opAnd:      newVal = oldVal & operand;
      heapOpPkg::opOr:       newVal = oldVal | operand;
      heapOpPkg::opXor:      newVal = oldVal ^ operand;
      default:               store  = 1'b0;              // Read-only ops
    endcase
    if (store && !(fromCheck.op inside {heapOpPkg::opAddAfter, heapOpPkg::opSubAfter}))
      resultC.data = newVal;
    if (fromCheck.op inside {heapOpPkg::opAlloc, heapOpPkg::opSize}) begin
      resultC                   = '0;               // Handle view, size zero on alloc
      resultC.handleView.handle = fromCheck.array;
      if (fromCheck.op == heapOpPkg::opSize)
        resultC.handleView.size = fromCheck.data.handleView.size;
    end
    if (fromCheck.op inside {heapOpPkg::opClear, heapOpPkg::opFree}) resultC = '0;
    if (fromCheck.error != heapOpPkg::errNone) begin     // Only forward failure
      store   = 1'b0;
      resultC = '0;
    end
  end

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) toPort.valid <= 1'b0;
    else         toPort.valid <= fromCheck.valid;
  end

  always_ff @(posedge clock) begin
    if (fromCheck.valid && store)
      mem[fromCheck.array][fromCheck.slot] <= newVal;
    toPort.data  <= resultC;
    toPort.error <= fromCheck.error;
  end

endmodule

`default_nettype wire

// ==== heapArrayMemory.sv ====
// --------------------------------------------------------------------------
// Array heap top level
// Request port, check stage and access stage in a loop
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module heapArrayMemory (
  input  logic                                  clock,
  input  logic                                  resetN,
  input  logic                                  req,
  input  heapOpPkg::heapOpE                     op,
  input  logic [heapGeometryPkg::arrayBits-1:0] array,
  input  logic [heapGeometryPkg::indexBits-1:0] index,
  input  logic [heapGeometryPkg::dataBits-1:0]  data,
  output logic                                  ack,
  output heapOpPkg::heapResultU                 result,
  output heapOpPkg::heapErrE                    error
);

  heapStageIf portToCheck ();                         // Request into check
  heapStageIf checkToAccess ();                       // Checked item
  heapStageIf accessToPort ();                        // Response link

  heapRequestPort requestPort (
    .clock      (clock),
    .resetN     (resetN),
    .req        (req),
    .op         (op),
    .array      (array),
    .index      (index),
    .data       (data),
    .ack        (ack),
    .result     (result),
    .error      (error),
    .toCheck    (portToCheck.source),
    .fromAccess (accessToPort.sink)
  );

  heapCheckStage checkStage (
    .clock    (clock),
    .resetN   (resetN),
    .fromPort (portToCheck.sink),
    .toAccess (checkToAccess.source)
  );

  heapAccessStage accessStage (
    .clock     (clock),
    .resetN    (resetN),
    .fromCheck (checkToAccess.sink),
    .toPort    (accessToPort.source)
  );

endmodule

`default_nettype wire

// ==== heapTb_checker.sv ====
// --------------------------------------------------------------------------
// Handshake assertions for the array heap top level
// Bound into heapArrayMemory from this file
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module heapTb_checker (
  input logic                                  clock,
  input logic                                  resetN,
  input logic                                  req,
  input heapOpPkg::heapOpE                     op,
  input logic [heapGeometryPkg::arrayBits-1:0] array,
  input logic [heapGeometryPkg::indexBits-1:0] index,
  input logic [heapGeometryPkg::dataBits-1:0]  data,
  input logic                                  ack
);

  int assertFails = 0;                                // Failed assertion count

  // Ack is registered, so the req behind it was sampled one edge earlier
  ackNeedsReq: assert property (@(posedge clock) disable iff (!resetN)
    $rose(ack) |-> $past(req))
    else begin
      $error("ack rose without a pending req");
      assertFails++;
    end

  fieldsStable: assert property (@(posedge clock) disable iff (!resetN)
    (req && !ack) ##1 req |-> $stable(op) && $stable(array)
                              && $stable(index) && $stable(data))
    else begin
      $error("request fields changed before ack");
      assertFails++;
    end

  ackFallsAfterReq: assert property (@(posedge clock) disable iff (!resetN)
    $fell(ack) |-> !$past(req))                       // Phase 4 follows phase 3
    else begin
      $error("ack fell while req was still high");
      assertFails++;
    end

endmodule

bind heapArrayMemory heapTb_checker handshakeCheck (
  .clock  (clock),
  .resetN (resetN),
  .req    (req),
  .op     (op),
  .array  (array),
  .index  (index),
  .data   (data),
  .ack    (ack)
);

`default_nettype wire

// ==== heapTests.svh ====
// --------------------------------------------------------------------------
// Directed tests for the array heap
// Included into the testbench module body
// --------------------------------------------------------------------------

// Fresh heap hands out arrays 0 to 3, then runs dry
task automatic testAllocation();
  startTest();
  for (int a = 0; a < heapGeometryPkg::arrayCount; a++)
    expectResult("alloc", heapOpPkg::opAlloc, 0, 0, '1, handleWord(a, 0));  // Data ignored
  expectError("alloc past last array", heapOpPkg::opAlloc, 0, 0, '0,
              heapOpPkg::errOutOfMemory);
  endTest("allocation");
endtask

task automatic testWriteRead();
  logic [heapGeometryPkg::dataBits-1:0] value;
  startTest();
  randomData(value);
  expectResult("write index 2", heapOpPkg::opWrite, 1, 2, value, dataWord(value));
  expectResult("size after write", heapOpPkg::opSize, 1, 0, '0, handleWord(1, 3));
  expectResult("read index 2", heapOpPkg::opRead, 1, 2, '0, dataWord(value));
  expectError("read index 3", heapOpPkg::opRead, 1, 3, '0, heapOpPkg::errOutOfBounds);
  endTest("write read size");
endtask

// Array 2 used as a stack, popped back in reverse
task automatic testPushPop();
  logic [heapGeometryPkg::dataBits-1:0] pushed [heapGeometryPkg::arrayLength];
  startTest();
  for (int i = 0; i < heapGeometryPkg::arrayLength; i++) begin
    randomData(pushed[i]);
    expectError("push", heapOpPkg::opPush, 2, 0, pushed[i], heapOpPkg::errNone);
  end
  expectError("push on full array", heapOpPkg::opPush, 2, 0, '0, heapOpPkg::errFull);
  for (int i = heapGeometryPkg::arrayLength - 1; i >= 0; i--)
    expectResult("pop", heapOpPkg::opPop, 2, 0, '0, dataWord(pushed[i]));
  expectError("pop on empty array", heapOpPkg::opPop, 2, 0, '0, heapOpPkg::errEmpty);
  endTest("push pop");
endtask

// Element arithmetic on 12 bits, wraps modulo 4096
function automatic int arithModel(input heapOpPkg::heapOpE kind, input int oldVal,
                                  input int operand);
  case (kind)
    heapOpPkg::opAdd, heapOpPkg::opAddAfter:           return (oldVal + operand) % 4096;
    heapOpPkg::opSubtract, heapOpPkg::opSubAfter:      return (oldVal - operand + 4096) % 4096;
    heapOpPkg::opAnd:                                  return oldVal & operand;
    heapOpPkg::opOr:                                   return oldVal | operand;
    default:                                           return oldVal ^ operand;
  endcase
endfunction

task automatic testArithmetic();
  heapOpPkg::heapOpE kinds [7] = '{heapOpPkg::opAdd, heapOpPkg::opAddAfter,
    heapOpPkg::opSubtract, heapOpPkg::opSubAfter, heapOpPkg::opAnd,
    heapOpPkg::opOr, heapOpPkg::opXor};
  logic [heapGeometryPkg::dataBits-1:0] operand;
  logic [heapGeometryPkg::dataBits-1:0] stored;           // Model of element 0
  logic [heapGeometryPkg::dataBits-1:0] updated;
  startTest();
  randomData(stored);
  expectResult("write base value", heapOpPkg::opWrite, 3, 0, stored, dataWord(stored));
  foreach (kinds[k]) begin
    randomData(operand);
    updated = heapGeometryPkg::dataBits'(arithModel(kinds[k], int'(stored), int'(operand)));
    if (kinds[k] inside {heapOpPkg::opAddAfter, heapOpPkg::opSubAfter})
      expectResult(kinds[k].name(), kinds[k], 3, 0, operand, dataWord(stored));
    else
      expectResult(kinds[k].name(), kinds[k], 3, 0, operand, dataWord(updated));
    stored = updated;
    expectResult("read after update", heapOpPkg::opRead, 3, 0, '0, dataWord(stored));
  end
  endTest("arithmetic");
endtask

// Freed arrays come back last in, first out
task automatic testFreeClear();
  startTest();
  expectError("free array 1", heapOpPkg::opFree, 1, 0, '0, heapOpPkg::errNone);
  expectError("read freed array", heapOpPkg::opRead, 1, 0, '0, heapOpPkg::errFreed);
  expectError("free array 2", heapOpPkg::opFree, 2, 0, '0, heapOpPkg::errNone);
  expectResult("alloc reuses last freed", heapOpPkg::opAlloc, 0, 0, '0, handleWord(2, 0));
  expectResult("alloc reuses older freed", heapOpPkg::opAlloc, 0, 0, '0, handleWord(1, 0));
  expectError("clear", heapOpPkg::opClear, 0, 0, '0, heapOpPkg::errNone);
  expectError("read after clear", heapOpPkg::opRead, 0, 0, '0,
              heapOpPkg::errNotAllocated);
  expectResult("alloc after clear", heapOpPkg::opAlloc, 0, 0, '0, handleWord(0, 0));
  endTest("free reuse clear");
endtask

// ==== heapTb.sv ====
// --------------------------------------------------------------------------
// Testbench for the array heap
// Clock, reset, LFSR data, four-phase driver, compare tasks and timeout
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module heapTb;

  localparam int requestCount = 42;                   // Requests over all tests
  localparam int cycleLimit   = requestCount * 10;

  logic                                  clock;
  logic                                  resetN;
  logic                                  req;
  heapOpPkg::heapOpE                     op;
  logic [heapGeometryPkg::arrayBits-1:0] array;
  logic [heapGeometryPkg::indexBits-1:0] index;
  logic [heapGeometryPkg::dataBits-1:0]  data;
  logic                                  ack;
  heapOpPkg::heapResultU                 result;
  heapOpPkg::heapErrE                    error;

  logic [31:0]           lfsrState;
  heapOpPkg::heapResultU gotResult;                   // Last response word
  heapOpPkg::heapErrE    gotError;
  int                    cycleCount;
  int                    failCount;                   // Whole run
  int                    testFails;                   // Current test only
  int                    testCount;

  heapArrayMemory i_dut (
    .clock  (clock),
    .resetN (resetN),
    .req    (req),
    .op     (op),
    .array  (array),
    .index  (index),
    .data   (data),
    .ack    (ack),
    .result (result),
    .error  (error)
  );

  initial begin
    clock = 1'b0;
    forever #4 clock = ~clock;                        // 8 ns period
  end

  always @(posedge clock) begin
    cycleCount++;
    if (cycleCount >= cycleLimit) begin
      $display("Timeout: the DUT gave no ack within %0d cycles", cycleLimit);
      $display("Test failures found");
      $finish;
    end
  end

  // --------------------------------------------------------------------------
  // Stimulus helpers
  // --------------------------------------------------------------------------
  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsrNext(input logic [31:0] state);
    return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
  endfunction

  task automatic randomData(output logic [heapGeometryPkg::dataBits-1:0] value);
    for (int b = 0; b < heapGeometryPkg::dataBits; b++) begin
      lfsrState = lfsrNext(lfsrState);                // One step per bit
      value[b]  = lfsrState[0];
    end
  endtask

  // Full four-phase handshake, entered and left 1 ns after an edge
  task automatic sendRequest(input heapOpPkg::heapOpE reqOp, input int reqArray,
                             input int reqIndex,
                             input logic [heapGeometryPkg::dataBits-1:0] reqData);
    op    = reqOp;
    array = heapGeometryPkg::arrayBits'(reqArray);
    index = heapGeometryPkg::indexBits'(reqIndex);
    data  = reqData;
    req   = 1'b1;
    do begin
      @(posedge clock);
      #1;
    end while (!ack);
    gotResult = result;                               // Valid while ack high
    gotError  = error;
    req       = 1'b0;
    while (ack) begin
      @(posedge clock);
      #1;
    end
  endtask

  // --------------------------------------------------------------------------
  // Compare tasks and expected words
  // --------------------------------------------------------------------------
  task automatic checkResult(input string what, input heapOpPkg::heapResultU got,
                             input heapOpPkg::heapResultU expected);
    if (got !== expected) begin
      $display("[FAIL] %0t ns: %s returned %h, expected %h", $time, what, got, expected);
      failCount++;
      testFails++;
    end
  endtask

  task automatic checkError(input string what, input heapOpPkg::heapErrE got,
                            input heapOpPkg::heapErrE expected);
    if (got !== expected) begin
      $display("[FAIL] %0t ns: %s gave error %s, expected %s", $time, what,
               got.name(), expected.name());
      failCount++;
      testFails++;
    end
  endtask

  // Handle in the bits above the size, zero padding on top
  function automatic heapOpPkg::heapResultU handleWord(input int handle, input int size);
    heapOpPkg::heapResultU word;
    word                   = '0;
    word.handleView.handle = heapGeometryPkg::arrayBits'(handle);
    word.handleView.size   = heapGeometryPkg::sizeBits'(size);
    return word;
  endfunction

  function automatic heapOpPkg::heapResultU dataWord(
      input logic [heapGeometryPkg::dataBits-1:0] value);
    heapOpPkg::heapResultU word;
    word.data = value;
    return word;
  endfunction

  task automatic expectResult(input string what, input heapOpPkg::heapOpE reqOp,
                              input int reqArray, input int reqIndex,
                              input logic [heapGeometryPkg::dataBits-1:0] reqData,
                              input heapOpPkg::heapResultU expected);
    sendRequest(reqOp, reqArray, reqIndex, reqData);
    checkError(what, gotError, heapOpPkg::errNone);
    checkResult(what, gotResult, expected);
  endtask

  // Judged by the error code alone
  task automatic expectError(input string what, input heapOpPkg::heapOpE reqOp,
                             input int reqArray, input int reqIndex,
                             input logic [heapGeometryPkg::dataBits-1:0] reqData,
                             input heapOpPkg::heapErrE expected);
    sendRequest(reqOp, reqArray, reqIndex, reqData);
    checkError(what, gotError, expected);
  endtask

  task automatic startTest();
    testFails = 0;
    testCount++;
  endtask

  task automatic endTest(input string name);
    if (testFails == 0) $display("Test %s: passed", name);
    else                $display("Test %s: %0d failures", name, testFails);
  endtask

  // --------------------------------------------------------------------------
  // Run
  // --------------------------------------------------------------------------
  initial begin
    lfsrState  = 32'hb98f_392a;
    cycleCount = 0;
    failCount  = 0;
    testFails  = 0;
    testCount  = 0;
    resetN     = 1'b0;
    req        = 1'b0;
    op         = heapOpPkg::opClear;
    array      = '0;
    index      = '0;
    data       = '0;
    repeat (3) @(posedge clock);
    #1;
    resetN = 1'b1;
    testAllocation();
    testWriteRead();
    testPushPop();
    testArithmetic();
    testFreeClear();
    failCount += i_dut.handshakeCheck.assertFails;    // Handshake assertion failures
    $display("Summary: %0d tests, %0d failures", testCount, failCount);
    if (failCount == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

  `include "heapTests.svh"

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+.
heapGeometryPkg.sv
heapOpPkg.sv
heapStageIf.sv
heapRequestPort.sv
heapCheckStage.sv
heapAccessStage.sv
heapArrayMemory.sv
heapTb_checker.sv
heapTb.sv
